// File: include/pw_defines.svh
// Sizes and credit depths for the banked line store. Lane count must be a power of two
// and PW_ADDR_BITS must equal PW_LANE_BITS plus log2 of PW_BANK_LINES.
`ifndef PW_DEFINES_SVH
`define PW_DEFINES_SVH

// Bytes per line
`define PW_LINE_BYTES 8

// Lanes and banks, and the low address bits that pick one of them
`define PW_N_LANES 4
`define PW_LANE_BITS 2

// Lines held by each bank, and the full line address width
`define PW_BANK_LINES 16
`define PW_ADDR_BITS 6

// Request tag width
`define PW_TAG_BITS 8

// Credit depths of every link, which also size the FIFOs behind them
`define PW_IN_CREDITS 4
`define PW_LANE_CREDITS 2
`define PW_RSP_LANE_CREDITS 2
`define PW_OUT_CREDITS 4

`endif

// File: sources.f
+incdir+include
verilog/pw_pkg.sv
verilog/pw_fifo.sv
verilog/pw_dispatch.sv
verilog/pw_line_bank.sv
verilog/pw_rmw_lane.sv
verilog/pw_rsp_merge.sv
verilog/pw_store_top.sv
tb/tb_pw_checker.sv
tb/tb_pw_store.sv

// File: tb/tb_pw_checker.sv
// Response checker for the line store. Expectations arrive by tag from the testbench,
// and every input is sampled on the rising clock edge.
`timescale 1ns/1ps
`default_nettype none

`include "pw_defines.svh"

module tb_pw_checker
(
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            req_valid,
    input  wire logic            req_credit,
    input  wire pw_pkg::t_pw_rsp rsp,
    input  wire logic            rsp_valid,
    input  wire logic            rsp_credit,
    input  wire pw_pkg::t_pw_rsp exp_rsp,
    input  wire logic            exp_valid,
    output int                   error_count,
    output int                   rsp_count,
    output int                   pending_count
);

    localparam int N_TAGS = 1 << `PW_TAG_BITS;

    // One slot per tag, set at issue and cleared by its response
    logic pending [N_TAGS];
    pw_pkg::t_pw_rsp exp_table [N_TAGS];

    // Mirrors of the credits held on both external links
    int req_credits;
    int out_credits;

    always @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < N_TAGS; i++)
            begin
                pending[i] = 1'b0;
            end
            error_count   = 0;
            rsp_count     = 0;
            pending_count = 0;
            req_credits   = `PW_IN_CREDITS;
            out_credits   = `PW_OUT_CREDITS;
        end
        else
        begin
            // ================================================================
            // Credit rules on both external links
            // ================================================================

            // A credit pulse seen in this sample was already usable by the sender
            req_credits = req_credits + int'(req_credit);
            if (req_credits > `PW_IN_CREDITS)
            begin
                $display("a request credit came back with no request left in the buffer");
                error_count++;
                req_credits = `PW_IN_CREDITS;
            end
            if (req_valid)
            begin
                if (req_credits == 0)
                begin
                    $display("a request was sent while no request credit was held");
                    error_count++;
                end
                else
                begin
                    req_credits--;
                end
            end

            // The DUT sent this response one edge ago, before this credit arrived
            if (rsp_valid)
            begin
                if (out_credits == 0)
                begin
                    $display("a response was sent beyond the response credits granted");
                    error_count++;
                end
                else
                begin
                    out_credits--;
                end
            end
            out_credits = out_credits + int'(rsp_credit);

            // ================================================================
            // Responses against the table
            // ================================================================

            if (rsp_valid)
            begin
                if (!pending[rsp.tag])
                begin
                    $display("response for tag %h has no outstanding request", rsp.tag);
                    error_count++;
                end
                else
                begin
                    if (rsp.is_write !== exp_table[rsp.tag].is_write)
                    begin
                        $display("ERROR rsp.is_write tag %h: expected %h, got %h",
                                 rsp.tag, exp_table[rsp.tag].is_write, rsp.is_write);
                        error_count++;
                    end
                    if (rsp.line !== exp_table[rsp.tag].line)
                    begin
                        $display("ERROR rsp.line tag %h: expected %h, got %h",
                                 rsp.tag, exp_table[rsp.tag].line, rsp.line);
                        error_count++;
                    end
                    pending[rsp.tag] = 1'b0;
                    pending_count--;
                    rsp_count++;
                end
            end

            // New expectations from the stimulus side
            if (exp_valid)
            begin
                exp_table[exp_rsp.tag] = exp_rsp;
                pending[exp_rsp.tag] = 1'b1;
                pending_count++;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_pw_store.sv
// Testbench for the banked line store. Inputs change on the falling edge, and every
// line is written before it is read, since bank contents start undefined.
`timescale 1ns/1ps
`default_nettype none

`include "pw_defines.svh"

module tb_pw_store;

    localparam int N_LINES = 1 << `PW_ADDR_BITS;
    // Full writes and reads, partial pairs, same-address runs, stall burst, random mix
    localparam int N_OPS = 2 * N_LINES + 32 + 20 + 6 + 300;
    localparam int CYCLE_LIMIT = N_OPS * 20 + 200;

    logic clk;
    logic reset;
    pw_pkg::t_pw_req req;
    logic req_valid;
    logic req_credit;
    pw_pkg::t_pw_rsp rsp;
    logic rsp_valid;
    logic rsp_credit;

    // Expectation handed to the checker in the cycle its request is sent
    pw_pkg::t_pw_rsp exp_rsp;
    logic exp_valid;

    int error_count;
    int rsp_count;
    int pending_count;

    // Reference copy of the whole store, updated at issue time
    pw_pkg::t_pw_line ref_mem [N_LINES];

    int req_credits;
    int issued;
    int owed;
    int cycle;
    logic withhold;
    logic [31:0] stim_seed;
    logic [31:0] credit_seed;

    pw_store_top i_pw_store_top
    (
        .clk(clk),
        .reset(reset),
        .req(req),
        .req_valid(req_valid),
        .req_credit(req_credit),
        .rsp(rsp),
        .rsp_valid(rsp_valid),
        .rsp_credit(rsp_credit)
    );

    tb_pw_checker i_checker
    (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req_credit(req_credit),
        .rsp(rsp),
        .rsp_valid(rsp_valid),
        .rsp_credit(rsp_credit),
        .exp_rsp(exp_rsp),
        .exp_valid(exp_valid),
        .error_count(error_count),
        .rsp_count(rsp_count),
        .pending_count(pending_count)
    );

    always #50 clk = ~clk;

    // ========================================================================
    // Random numbers and the reference model
    // ========================================================================

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Only the upper half of the state is used, the low bits cycle too fast
    function automatic logic [15:0] stim_rand();
        stim_seed = lcg_step(stim_seed);
        return stim_seed[31:16];
    endfunction

    function automatic pw_pkg::t_pw_line rand_line();
        return {stim_rand(), stim_rand(), stim_rand(), stim_rand()};
    endfunction

    // New line content after a request; a read leaves the line as it was
    function automatic pw_pkg::t_pw_line pw_ref_line(input pw_pkg::t_pw_line old,
                                                     input pw_pkg::t_pw_op op,
                                                     input pw_pkg::t_pw_line data,
                                                     input pw_pkg::t_pw_mask mask);
        pw_pkg::t_pw_line line;
        line = old;
        if (op == pw_pkg::pw_op_write)
        begin
            line = data;
        end
        else if (op == pw_pkg::pw_op_pwrite)
        begin
            for (int b = 0; b < `PW_LINE_BYTES; b++)
            begin
                if (mask[b])
                begin
                    line[b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
        return line;
    endfunction

    // ========================================================================
    // Stimulus helpers
    // ========================================================================

    // A credit pulse lasts one cycle, so each falling edge sees it exactly once
    task automatic next_cycle();
        @(negedge clk);
        req_credits = req_credits + int'(req_credit);
    endtask

    // Called on a falling edge; sends one request once a credit is held
    task automatic issue_req(input pw_pkg::t_pw_op op, input pw_pkg::t_pw_addr addr,
                             input pw_pkg::t_pw_line data, input pw_pkg::t_pw_mask mask);
        pw_pkg::t_pw_req r;
        pw_pkg::t_pw_rsp e;
        while (req_credits == 0)
        begin
            next_cycle();
        end
        r.op   = op;
        r.addr = addr;
        r.tag  = pw_pkg::t_pw_tag'(issued);
        r.data = data;
        r.mask = mask;
        // Valid at issue time because one address always maps to one in-order lane
        e.tag      = r.tag;
        e.is_write = (op != pw_pkg::pw_op_read);
        e.line     = (op == pw_pkg::pw_op_read) ? ref_mem[addr] : '0;
        ref_mem[addr] = pw_ref_line(ref_mem[addr], op, data, mask);
        req       = r;
        req_valid = 1'b1;
        exp_rsp   = e;
        exp_valid = 1'b1;
        req_credits--;
        issued++;
        next_cycle();
        req_valid = 1'b0;
        exp_valid = 1'b0;
    endtask

    task automatic issue_random();
        pw_pkg::t_pw_op op;
        pw_pkg::t_pw_addr addr;
        op   = pw_pkg::t_pw_op'(stim_rand() % 3);
        addr = pw_pkg::t_pw_addr'(stim_rand());
        issue_req(op, addr, rand_line(), pw_pkg::t_pw_mask'(stim_rand()));
    endtask

    task automatic print_counts();
        $display("checked %0d of %0d responses, %0d missing, %0d errors",
                 rsp_count, issued, pending_count, error_count);
    endtask

    // ========================================================================
    // Response credits and run limit
    // ========================================================================

    // Credits go back for responses already seen, on about three cycles in four
    always @(negedge clk)
    begin
        if (reset)
        begin
            owed = 0;
            rsp_credit = 1'b0;
        end
        else
        begin
            credit_seed = lcg_step(credit_seed);
            if (rsp_valid)
            begin
                owed++;
            end
            if ((owed > 0) && !withhold && (credit_seed[17:16] != 2'b00))
            begin
                rsp_credit = 1'b1;
                owed--;
            end
            else
            begin
                rsp_credit = 1'b0;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle++;
        if (cycle >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles with %0d responses never received",
                     cycle, pending_count);
            print_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        req = '0;
        req_valid = 1'b0;
        rsp_credit = 1'b0;
        exp_rsp = '0;
        exp_valid = 1'b0;
        withhold = 1'b0;
        owed = 0;
        issued = 0;
        cycle = 0;
        req_credits = `PW_IN_CREDITS;
        stim_seed = 32'd14041;
        // Credit returns run one step ahead of the stimulus sequence
        credit_seed = lcg_step(32'd14041);
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        next_cycle();

        // Every line written in full, then read back
        for (int a = 0; a < N_LINES; a++)
        begin
            issue_req(pw_pkg::pw_op_write, pw_pkg::t_pw_addr'(a), rand_line(), '1);
        end
        for (int a = 0; a < N_LINES; a++)
        begin
            issue_req(pw_pkg::pw_op_read, pw_pkg::t_pw_addr'(a), '0, '0);
        end

        // Partial writes each followed by a read, every fourth with a zero mask
        for (int i = 0; i < 16; i++)
        begin
            pw_pkg::t_pw_addr addr;
            pw_pkg::t_pw_mask mask;
            addr = pw_pkg::t_pw_addr'(stim_rand());
            mask = (i % 4 == 0) ? '0 : pw_pkg::t_pw_mask'(stim_rand());
            issue_req(pw_pkg::pw_op_pwrite, addr, rand_line(), mask);
            issue_req(pw_pkg::pw_op_read, addr, '0, '0);
        end

        // Back-to-back runs on one address per lane
        for (int i = 0; i < 4; i++)
        begin
            pw_pkg::t_pw_addr addr;
            addr = pw_pkg::t_pw_addr'(i * 5);
            issue_req(pw_pkg::pw_op_pwrite, addr, rand_line(), pw_pkg::t_pw_mask'(stim_rand()));
            issue_req(pw_pkg::pw_op_pwrite, addr, rand_line(), pw_pkg::t_pw_mask'(stim_rand()));
            issue_req(pw_pkg::pw_op_read, addr, '0, '0);
            issue_req(pw_pkg::pw_op_pwrite, addr, rand_line(), pw_pkg::t_pw_mask'(stim_rand()));
            issue_req(pw_pkg::pw_op_read, addr, '0, '0);
        end

        // Earlier traffic drains first, so the burst starts with empty buffers
        while (rsp_count != issued)
        begin
            next_cycle();
        end

        // Short burst while response credits are held back; the store buffers
        // more than six requests, so this cannot lock up
        @(posedge clk);
        withhold = 1'b1;
        next_cycle();
        for (int i = 0; i < 6; i++)
        begin
            issue_random();
        end
        repeat (40) next_cycle();
        @(posedge clk);
        withhold = 1'b0;
        next_cycle();

        for (int i = 0; i < 300; i++)
        begin
            issue_random();
        end

        // Drain, then leave room for any stray extra response
        while (rsp_count != issued)
        begin
            next_cycle();
        end
        repeat (20) next_cycle();

        print_counts();
        if ((error_count == 0) && (rsp_count == issued) && (pending_count == 0))
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/pw_dispatch.sv
// Request buffer that routes by the low address bits. A head whose lane has no
// credit blocks every request behind it.
`timescale 1ns/1ps
`default_nettype none

`include "pw_defines.svh"

module pw_dispatch
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire pw_pkg::t_pw_req        req,
    input  wire logic                   req_valid,
    input  wire logic [`PW_N_LANES-1:0] lane_credit,
    output logic                        req_credit,
    output pw_pkg::t_pw_req             lane_req,
    output logic [`PW_N_LANES-1:0]      lane_req_valid
);

    localparam int CNT_BITS = $clog2(`PW_LANE_CREDITS + 1);

    pw_pkg::t_pw_req head;
    logic head_valid;
    logic [`PW_LANE_BITS-1:0] head_lane;
    logic send;

    // Credits held toward each lane's input FIFO
    logic [CNT_BITS-1:0] lane_cnt [`PW_N_LANES];

    // The outside only sends while it holds a credit, so the buffer
    // never takes more than PW_IN_CREDITS requests
    pw_fifo
    #(
        .DEPTH(`PW_IN_CREDITS),
        .T(pw_pkg::t_pw_req)
    )
    i_req_fifo
    (
        .clk(clk),
        .reset(reset),
        .enq_en(req_valid),
        .enq_data(req),
        .deq_en(send),
        .first(head),
        .not_empty(head_valid)
    );

    assign head_lane = head.addr[`PW_LANE_BITS-1:0];
    assign send = head_valid && (lane_cnt[head_lane] != '0);

    // The request bus is shared by all lanes and only the valid bit is
    // steered, so the payload register needs no reset
    always_ff @(posedge clk)
    begin
        lane_req <= head;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req_credit     <= 1'b0;
            lane_req_valid <= '0;
            for (int k = 0; k < `PW_N_LANES; k++)
            begin
                lane_cnt[k] <= CNT_BITS'(`PW_LANE_CREDITS);
            end
        end
        else
        begin
            // Every pop frees one slot of the input buffer
            req_credit <= send;
            for (int k = 0; k < `PW_N_LANES; k++)
            begin
                lane_req_valid[k] <= send && (head_lane == k);
                lane_cnt[k] <= lane_cnt[k] + CNT_BITS'(lane_credit[k])
                               - CNT_BITS'(send && (head_lane == k));
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/pw_fifo.sv
// Register-array FIFO with no full flag. The sender's credits must keep it from
// overflowing, and deq_en may only be raised while not_empty is high.
`timescale 1ns/1ps
`default_nettype none

module pw_fifo
#(
    parameter int DEPTH = 2,
    parameter type T = logic
)
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic enq_en,
    input  wire T     enq_data,
    input  wire logic deq_en,
    output T          first,
    output logic      not_empty
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    // Head entry is read straight from the array
    assign first = mem[rd_ptr];
    assign not_empty = (count != '0);

    // Storage itself is written without reset
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Pointers wrap explicitly so that DEPTH need not be a power of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (deq_en)
            begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_BITS'(enq_en) - CNT_BITS'(deq_en);
        end
    end

endmodule

`default_nettype wire

// File: verilog/pw_line_bank.sv
// One bank of line memory with a registered read. Contents are undefined until
// written, and a read of the line being written returns the old data.
`timescale 1ns/1ps
`default_nettype none

`include "pw_defines.svh"

module pw_line_bank
(
    input  wire logic                 clk,
    input  wire logic                 wr_en,
    input  wire pw_pkg::t_pw_bank_idx wr_idx,
    input  wire pw_pkg::t_pw_line     wr_data,
    input  wire pw_pkg::t_pw_mask     wr_bytes,
    input  wire logic                 rd_en,
    input  wire pw_pkg::t_pw_bank_idx rd_idx,
    output pw_pkg::t_pw_line          rd_data
);

    pw_pkg::t_pw_line mem [`PW_BANK_LINES];

    // Each byte lane has its own write enable
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int b = 0; b < `PW_LINE_BYTES; b++)
            begin
                if (wr_bytes[b])
                begin
                    mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // Read data shows up the cycle after rd_en and holds until the
    // next read
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// File: verilog/pw_pkg.sv
// Shared request and response types. Widths follow pw_defines.svh.
`default_nettype none

`include "pw_defines.svh"

package pw_pkg;

    // ========================================================================
    // Basic fields
    // ========================================================================

    // Read, full-line write, or byte-masked write
    typedef enum logic [1:0]
    {
        pw_op_read   = 2'd0,
        pw_op_write  = 2'd1,
        pw_op_pwrite = 2'd2
    } t_pw_op;

    // One line of data, byte 0 in the low bits
    typedef logic [`PW_LINE_BYTES*8-1:0] t_pw_line;

    // One enable bit per byte of a line
    typedef logic [`PW_LINE_BYTES-1:0] t_pw_mask;

    // Line address, lane select in the low bits and bank index above it
    typedef logic [`PW_ADDR_BITS-1:0] t_pw_addr;

    // Index of a line inside one bank
    typedef logic [`PW_ADDR_BITS-`PW_LANE_BITS-1:0] t_pw_bank_idx;

    typedef logic [`PW_TAG_BITS-1:0] t_pw_tag;

    // ========================================================================
    // Request and response
    // ========================================================================

    // The mask only matters for partial writes
    typedef struct packed
    {
        t_pw_op   op;
        t_pw_addr addr;
        t_pw_tag  tag;
        t_pw_line data;
        t_pw_mask mask;
    } t_pw_req;

    // Write acknowledgements carry a zero line
    typedef struct packed
    {
        t_pw_tag  tag;
        logic     is_write;
        t_pw_line line;
    } t_pw_rsp;

endpackage

`default_nettype wire

// File: verilog/pw_rmw_lane.sv
// Per-bank engine; partial writes become read, merge and full-line write, and the lane
// takes no other request meanwhile. A response credit is reserved at dequeue time.
`timescale 1ns/1ps
`default_nettype none

`include "pw_defines.svh"

module pw_rmw_lane
(
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire pw_pkg::t_pw_req lane_req,
    input  wire logic            lane_req_valid,
    input  wire logic            merge_credit,
    output logic                 lane_credit,
    output pw_pkg::t_pw_rsp      rsp,
    output logic                 rsp_valid
);

    localparam int CNT_BITS = $clog2(`PW_RSP_LANE_CREDITS + 1);

    // Progress of a read-modify-write after its dequeue
    typedef enum logic [1:0]
    {
        rmw_idle,
        rmw_read,
        rmw_merge
    } t_rmw_state;

    t_rmw_state rmw_state;

    pw_pkg::t_pw_req head;
    logic head_valid;
    logic deq;

    // Credits toward this lane's buffer in the merger
    logic [CNT_BITS-1:0] rsp_cnt;

    // Stage 1 holds the dequeued request, and keeps it through a RMW
    pw_pkg::t_pw_req s1_req;
    logic s1_valid;

    // Stage 2 holds what the response needs besides the read line
    logic s2_valid;
    pw_pkg::t_pw_tag s2_tag;
    logic s2_is_write;

    pw_pkg::t_pw_bank_idx bank_idx;
    pw_pkg::t_pw_line rd_data;
    pw_pkg::t_pw_line merged;
    logic rd_en;
    logic wr_en;

    pw_fifo
    #(
        .DEPTH(`PW_LANE_CREDITS),
        .T(pw_pkg::t_pw_req)
    )
    i_req_fifo
    (
        .clk(clk),
        .reset(reset),
        .enq_en(lane_req_valid),
        .enq_data(lane_req),
        .deq_en(deq),
        .first(head),
        .not_empty(head_valid)
    );

    // ========================================================================
    // Dequeue and bank control
    // ========================================================================

    // No dequeue without a response slot or while a RMW holds the bank
    assign deq = head_valid && (rsp_cnt != '0) && (rmw_state == rmw_idle);

    // Bits above the lane select index the line inside this bank
    assign bank_idx = s1_req.addr[`PW_ADDR_BITS-1:`PW_LANE_BITS];

    // Reads and partial writes both read the bank the cycle after dequeue
    assign rd_en = s1_valid && (s1_req.op != pw_pkg::pw_op_write);

    // A full write goes in the cycle after dequeue, a merged line one cycle later
    assign wr_en = (s1_valid && (s1_req.op == pw_pkg::pw_op_write)) ||
                   (rmw_state == rmw_merge);

    // New bytes where the mask is set, the old line everywhere else
    always_comb
    begin
        for (int b = 0; b < `PW_LINE_BYTES; b++)
        begin
            merged[b*8 +: 8] = s1_req.mask[b] ? s1_req.data[b*8 +: 8] : rd_data[b*8 +: 8];
        end
    end

    pw_line_bank i_bank
    (
        .clk(clk),
        .wr_en(wr_en),
        .wr_idx(bank_idx),
        .wr_data((rmw_state == rmw_merge) ? merged : s1_req.data),
        .wr_bytes('1),
        .rd_en(rd_en),
        .rd_idx(bank_idx),
        .rd_data(rd_data)
    );

    // ========================================================================
    // Pipeline and RMW state
    // ========================================================================

    // Payload registers; s1_req only changes on dequeue
    always_ff @(posedge clk)
    begin
        if (deq)
        begin
            s1_req <= head;
        end
        s2_tag <= s1_req.tag;
        s2_is_write <= (s1_req.op != pw_pkg::pw_op_read);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rmw_state   <= rmw_idle;
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            lane_credit <= 1'b0;
            rsp_cnt     <= CNT_BITS'(`PW_RSP_LANE_CREDITS);
        end
        else
        begin
            s1_valid <= deq;
            lane_credit <= deq;
            rsp_cnt <= rsp_cnt + CNT_BITS'(merge_credit) - CNT_BITS'(deq);

            // A partial write answers only after its merged line is written
            s2_valid <= (s1_valid && (s1_req.op != pw_pkg::pw_op_pwrite)) ||
                        (rmw_state == rmw_merge);

            case (rmw_state)
                rmw_idle:
                    if (deq && (head.op == pw_pkg::pw_op_pwrite))
                    begin
                        rmw_state <= rmw_read;
                    end
                rmw_read:
                    rmw_state <= rmw_merge;
                default:
                    rmw_state <= rmw_idle;
            endcase
        end
    end

    // The read line sits in the bank's output register during stage 2
    always_comb
    begin
        rsp.tag = s2_tag;
        rsp.is_write = s2_is_write;
        rsp.line = s2_is_write ? '0 : rd_data;
    end

    assign rsp_valid = s2_valid;

endmodule

`default_nettype wire

// File: verilog/pw_rsp_merge.sv
// Per-lane response buffers drained round-robin, one response per cycle while an
// external credit is held. Lanes reserve buffer space by credit before sending.
`timescale 1ns/1ps
`default_nettype none

`include "pw_defines.svh"

module pw_rsp_merge
(
    input  wire logic                                   clk,
    input  wire logic                                   reset,
    input  wire pw_pkg::t_pw_rsp [`PW_N_LANES-1:0]      lane_rsp,
    input  wire logic [`PW_N_LANES-1:0]                 lane_rsp_valid,
    input  wire logic                                   rsp_credit,
    output logic [`PW_N_LANES-1:0]                      merge_credit,
    output pw_pkg::t_pw_rsp                             rsp,
    output logic                                        rsp_valid
);

    localparam int CNT_BITS = $clog2(`PW_OUT_CREDITS + 1);

    pw_pkg::t_pw_rsp [`PW_N_LANES-1:0] buf_first;
    logic [`PW_N_LANES-1:0] buf_valid;
    logic [`PW_N_LANES-1:0] pop;

    // Last lane served, and the lane picked this cycle
    logic [`PW_LANE_BITS-1:0] rr_ptr;
    logic [`PW_LANE_BITS-1:0] sel;
    logic sel_valid;
    logic [CNT_BITS-1:0] out_cnt;

    for (genvar k = 0; k < `PW_N_LANES; k++)
    begin : g_buf
        pw_fifo
        #(
            .DEPTH(`PW_RSP_LANE_CREDITS),
            .T(pw_pkg::t_pw_rsp)
        )
        i_rsp_fifo
        (
            .clk(clk),
            .reset(reset),
            .enq_en(lane_rsp_valid[k]),
            .enq_data(lane_rsp[k]),
            .deq_en(pop[k]),
            .first(buf_first[k]),
            .not_empty(buf_valid[k])
        );
    end

    // Search starts just past the last lane served; lane count is a power of two
    always_comb
    begin
        logic [`PW_LANE_BITS-1:0] idx;
        sel = rr_ptr;
        sel_valid = 1'b0;
        for (int i = 1; i <= `PW_N_LANES; i++)
        begin
            idx = rr_ptr + `PW_LANE_BITS'(i);
            if (!sel_valid && buf_valid[idx])
            begin
                sel = idx;
                sel_valid = 1'b1;
            end
        end
        pop = '0;
        pop[sel] = sel_valid && (out_cnt != '0);
    end

    always_ff @(posedge clk)
    begin
        rsp <= buf_first[sel];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rr_ptr       <= '0;
            rsp_valid    <= 1'b0;
            merge_credit <= '0;
            out_cnt      <= CNT_BITS'(`PW_OUT_CREDITS);
        end
        else
        begin
            rsp_valid <= |pop;
            merge_credit <= pop;
            out_cnt <= out_cnt + CNT_BITS'(rsp_credit) - CNT_BITS'(|pop);
            if (|pop)
            begin
                rr_ptr <= sel;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/pw_store_top.sv
// Banked line store top: dispatcher, one RMW lane per bank, response merger.
// Every link is credit based; the outside starts with PW_IN_CREDITS request credits.
`timescale 1ns/1ps
`default_nettype none

`include "pw_defines.svh"

module pw_store_top
(
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire pw_pkg::t_pw_req req,
    input  wire logic            req_valid,
    output logic                 req_credit,
    output pw_pkg::t_pw_rsp      rsp,
    output logic                 rsp_valid,
    input  wire logic            rsp_credit
);

    // Dispatcher to lanes, one shared request bus with a valid per lane
    pw_pkg::t_pw_req lane_req;
    logic [`PW_N_LANES-1:0] lane_req_valid;
    logic [`PW_N_LANES-1:0] lane_credit;

    // Lanes to merger
    pw_pkg::t_pw_rsp [`PW_N_LANES-1:0] lane_rsp;
    logic [`PW_N_LANES-1:0] lane_rsp_valid;
    logic [`PW_N_LANES-1:0] merge_credit;

    pw_dispatch i_dispatch
    (
        .clk(clk),
        .reset(reset),
        .req(req),
        .req_valid(req_valid),
        .lane_credit(lane_credit),
        .req_credit(req_credit),
        .lane_req(lane_req),
        .lane_req_valid(lane_req_valid)
    );

    // Lane k owns every address whose low bits equal k
    for (genvar k = 0; k < `PW_N_LANES; k++)
    begin : g_lane
        pw_rmw_lane i_lane
        (
            .clk(clk),
            .reset(reset),
            .lane_req(lane_req),
            .lane_req_valid(lane_req_valid[k]),
            .merge_credit(merge_credit[k]),
            .lane_credit(lane_credit[k]),
            .rsp(lane_rsp[k]),
            .rsp_valid(lane_rsp_valid[k])
        );
    end

    pw_rsp_merge i_merge
    (
        .clk(clk),
        .reset(reset),
        .lane_rsp(lane_rsp),
        .lane_rsp_valid(lane_rsp_valid),
        .rsp_credit(rsp_credit),
        .merge_credit(merge_credit),
        .rsp(rsp),
        .rsp_valid(rsp_valid)
    );

endmodule

`default_nettype wire
